//--- Makefile
# Verilator build and run of the dispatcher testbench

VERILATOR ?= verilator
TOP       ?= tb_dispatcher
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

# Build, run, then decide from the log
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q -F '*** PASSED ***' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- include/dispatcher_settings.svh
/*
 * Dispatcher sizing
 * Widths and limits shared by the staging-RAM to tile-RAM copy engine
 * and its testbench
 */
`ifndef DISPATCHER_SETTINGS_SVH
`define DISPATCHER_SETTINGS_SVH

// Line payload, one mantissa block plus its shared exponent
`define DISP_MAN_W          256
`define DISP_EXP_W          8

// Address width of both the staging RAM and each tile RAM (512 deep)
`define DISP_ADDR_W         9

// Tile columns in one row
`define DISP_COLS           24

// Vector count and batch size fields
`define DISP_CNT_W          8
// Line counter within a batch, holds up to 255 vectors of 4 lines
`define DISP_LINE_W         10
`define DISP_LINES_PER_VEC  4

`endif

//--- logic/batch_walker.sv
/*
 * Batch walker
 * Emits one copy step per cycle with source and destination addresses
 * and the tile column mask, batch by batch, in broadcast or distribute
 * order
 */
`timescale 1ns/1ps
`default_nettype none

`include "dispatcher_settings.svh"

module batch_walker (
    input  wire                        i_clk,
    input  wire                        i_reset_n,
    input  wire                        i_start,
    input  wire dispatcher_pkg::disp_cfg_t i_cfg,
    output dispatcher_pkg::line_step_t o_step,
    output logic                       o_walk_done
);
    localparam int col_w = $clog2(`DISP_COLS);
    localparam logic [`DISP_COLS-1:0] one_col = 1;

    logic                    active;
    logic [`DISP_LINE_W-1:0] line_cnt;
    logic [`DISP_CNT_W-1:0]  batch_cnt;
    logic [`DISP_ADDR_W-1:0] src_base;
    logic [`DISP_ADDR_W-1:0] dst_off;
    logic [col_w-1:0]        cur_col;
    logic [col_w-1:0]        low_col;
    logic [col_w-1:0]        up_col;
    logic                    found_up;
    logic                    last_line;
    logic                    last_batch;
    logic [`DISP_ADDR_W-1:0] batch_step;
    logic [`DISP_ADDR_W-1:0] line_addr;

    assign last_line  = (line_cnt == i_cfg.batch_lines - 1'b1);
    assign last_batch = (batch_cnt == i_cfg.total_batches - 1'b1);
    // Offsets wrap at the RAM depth
    assign batch_step = i_cfg.batch_lines[`DISP_ADDR_W-1:0];
    assign line_addr  = line_cnt[`DISP_ADDR_W-1:0];

    // Lowest enabled column, and the nearest enabled one above cur_col
    always_comb begin
        low_col  = '0;
        up_col   = '0;
        found_up = 1'b0;
        // Scan downward so the last hit is the lowest
        for (int i = `DISP_COLS - 1; i >= 0; i--) begin
            if (i_cfg.col_en[i]) begin
                low_col = col_w'(i);
                if (i > int'(cur_col)) begin
                    up_col   = col_w'(i);
                    found_up = 1'b1;
                end
            end
        end
    end

    // ==========================================================
    // Line, batch and column counters
    // ==========================================================
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            active    <= 1'b0;
            line_cnt  <= '0;
            batch_cnt <= '0;
            src_base  <= '0;
            dst_off   <= '0;
            cur_col   <= '0;
        end else if (i_start) begin
            active    <= (i_cfg.total_batches != '0);
            line_cnt  <= '0;
            batch_cnt <= '0;
            src_base  <= '0;
            dst_off   <= '0;
            cur_col   <= low_col;
        end else if (active) begin
            if (last_line) begin
                line_cnt  <= '0;
                batch_cnt <= batch_cnt + 1'b1;
                src_base  <= src_base + batch_step;
                if (last_batch) active <= 1'b0;
                if (i_cfg.broadcast) begin
                    dst_off <= dst_off + batch_step;
                end else begin
                    cur_col <= found_up ? up_col : low_col;
                    // Every enabled column has had this offset
                    if (!found_up) dst_off <= dst_off + batch_step;
                end
            end else begin
                line_cnt <= line_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        o_step = '0;
        if (active) begin
            o_step.valid    = 1'b1;
            o_step.src_addr = src_base + line_addr;
            o_step.dst_addr = i_cfg.tile_addr + dst_off + line_addr;
            o_step.col_mask = i_cfg.broadcast ? i_cfg.col_en
                                              : (i_cfg.col_en & (one_col << cur_col));
            o_step.right    = i_cfg.right;
        end
    end

    // Final step, or straight away when there is nothing to copy
    assign o_walk_done = (active && last_line && last_batch)
                       || (i_start && (i_cfg.total_batches == '0));

endmodule

`default_nettype wire

//--- logic/dispatch_ctrl.sv
/*
 * Dispatch controller
 * Detects the rising edge of the enable, captures the command with its
 * derived batch counts, starts the walker and pulses done once the
 * last write has left the pipeline
 */
`timescale 1ns/1ps
`default_nettype none

`include "dispatcher_settings.svh"

module dispatch_ctrl (
    input  wire                        i_clk,
    input  wire                        i_reset_n,
    input  wire                        i_disp_en,
    input  wire dispatcher_pkg::disp_cmd_t i_cmd,
    input  wire                        i_walk_done,
    output dispatcher_pkg::disp_cfg_t  o_cfg,
    output logic                       o_start,
    output logic                       o_disp_done
);
    import dispatcher_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_busy,
        st_drain,
        st_done
    } state_t;

    state_t                  state;
    logic                    en_prev;
    logic                    trigger;
    logic                    start_r;
    disp_cfg_t               cfg_r;
    logic [`DISP_LINE_W-1:0] batch_lines;
    logic [`DISP_CNT_W-1:0]  total_batches;

    // Only a fresh rising edge while idle starts a transfer
    assign trigger = i_disp_en && !en_prev && (state == st_idle);

    // Four lines per vector
    assign batch_lines = `DISP_LINE_W'(i_cmd.vec_size) * `DISP_LINE_W'(`DISP_LINES_PER_VEC);
    // Zero batch size means nothing to copy
    assign total_batches = (i_cmd.vec_size == '0) ? '0 : i_cmd.nv_cnt / i_cmd.vec_size;

    // ==========================================================
    // State and edge detect
    // ==========================================================
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            state   <= st_idle;
            en_prev <= 1'b0;
            start_r <= 1'b0;
        end else begin
            en_prev <= i_disp_en;
            start_r <= trigger;
            case (state)
                st_idle:  if (trigger) state <= st_busy;
                st_busy:  if (i_walk_done) state <= st_drain;
                // Last write still in flight behind the RAM latency
                st_drain: state <= st_done;
                default:  state <= st_idle;
            endcase
        end
    end

    // Command capture, held until the next trigger
    always_ff @(posedge i_clk) begin
        if (trigger) begin
            cfg_r.tile_addr     <= i_cmd.tile_addr;
            cfg_r.batch_lines   <= batch_lines;
            cfg_r.total_batches <= total_batches;
            cfg_r.col_en        <= i_cmd.col_en;
            cfg_r.right         <= i_cmd.right;
            cfg_r.broadcast     <= i_cmd.broadcast;
        end
    end

    assign o_cfg       = cfg_r;
    assign o_start     = start_r;
    assign o_disp_done = (state == st_done);

endmodule

`default_nettype wire

//--- logic/dispatcher_pkg.sv
/*
 * Dispatcher types
 * Packed structs for RAM lines, the copy command, the captured
 * configuration, one copy step and the RAM read/write requests
 */
`default_nettype none

`include "dispatcher_settings.svh"

package dispatcher_pkg;

    // One RAM line, mantissa and exponent move as a unit
    typedef struct packed {
        logic [`DISP_MAN_W-1:0]  man;
        logic [`DISP_EXP_W-1:0]  exp;
    } line_word_t;

    // Command as presented by the master
    typedef struct packed {
        logic [`DISP_ADDR_W-1:0] tile_addr;
        logic [`DISP_CNT_W-1:0]  nv_cnt;
        logic [`DISP_CNT_W-1:0]  vec_size;
        logic [`DISP_COLS-1:0]   col_en;
        logic                    right;
        logic                    broadcast;
    } disp_cmd_t;

    // Captured command with derived counts
    typedef struct packed {
        logic [`DISP_ADDR_W-1:0] tile_addr;
        logic [`DISP_LINE_W-1:0] batch_lines;
        logic [`DISP_CNT_W-1:0]  total_batches;
        logic [`DISP_COLS-1:0]   col_en;
        logic                    right;
        logic                    broadcast;
    } disp_cfg_t;

    // One line to copy
    typedef struct packed {
        logic                    valid;
        logic [`DISP_ADDR_W-1:0] src_addr;
        logic [`DISP_ADDR_W-1:0] dst_addr;
        logic [`DISP_COLS-1:0]   col_mask;
        logic                    right;
    } line_step_t;

    typedef struct packed {
        logic                    en;
        logic [`DISP_ADDR_W-1:0] addr;
    } ram_rd_t;

    typedef struct packed {
        logic                    en;
        logic [`DISP_ADDR_W-1:0] addr;
        line_word_t              word;
    } tile_wr_t;

endpackage

`default_nettype wire

//--- logic/dispatcher_top.sv
/*
 * Dispatcher
 * Copies batches of lines from the left or right staging RAM into the
 * tile RAMs of one row, broadcast to all enabled columns or spread
 * across them in turn
 */
`timescale 1ns/1ps
`default_nettype none

`include "dispatcher_settings.svh"

module dispatcher_top (
    input  wire                         i_clk,
    input  wire                         i_reset_n,
    input  wire                         i_disp_en,
    input  wire dispatcher_pkg::disp_cmd_t  i_cmd,
    input  wire dispatcher_pkg::line_word_t i_left_rd_data,
    input  wire dispatcher_pkg::line_word_t i_right_rd_data,
    output dispatcher_pkg::ram_rd_t     o_left_rd,
    output dispatcher_pkg::ram_rd_t     o_right_rd,
    output dispatcher_pkg::tile_wr_t    o_left_wr,
    output dispatcher_pkg::tile_wr_t    o_right_wr,
    output logic [`DISP_COLS-1:0]       o_tile_wr_en,
    output logic                        o_disp_done
);
    import dispatcher_pkg::*;

    disp_cfg_t  cfg;
    logic       start;
    logic       walk_done;
    line_step_t step;
    line_step_t step_d;

    // Command FSM
    dispatch_ctrl u_ctrl (
        .i_clk       (i_clk),
        .i_reset_n   (i_reset_n),
        .i_disp_en   (i_disp_en),
        .i_cmd       (i_cmd),
        .i_walk_done (walk_done),
        .o_cfg       (cfg),
        .o_start     (start),
        .o_disp_done (o_disp_done)
    );

    batch_walker u_walker (
        .i_clk       (i_clk),
        .i_reset_n   (i_reset_n),
        .i_start     (start),
        .i_cfg       (cfg),
        .o_step      (step),
        .o_walk_done (walk_done)
    );

    // Read then write, one cycle apart
    stage_read_port u_rd (
        .i_clk      (i_clk),
        .i_reset_n  (i_reset_n),
        .i_step     (step),
        .o_left_rd  (o_left_rd),
        .o_right_rd (o_right_rd),
        .o_step_d   (step_d)
    );

    tile_write_port u_wr (
        .i_step_d        (step_d),
        .i_left_rd_data  (i_left_rd_data),
        .i_right_rd_data (i_right_rd_data),
        .o_left_wr       (o_left_wr),
        .o_right_wr      (o_right_wr),
        .o_tile_wr_en    (o_tile_wr_en)
    );

endmodule

`default_nettype wire

//--- logic/stage_read_port.sv
/*
 * Staging-RAM read port
 * Issues the read on the side chosen by the step and delays the step
 * by one cycle to meet the returning data
 */
`timescale 1ns/1ps
`default_nettype none

module stage_read_port (
    input  wire                         i_clk,
    input  wire                         i_reset_n,
    input  wire dispatcher_pkg::line_step_t i_step,
    output dispatcher_pkg::ram_rd_t     o_left_rd,
    output dispatcher_pkg::ram_rd_t     o_right_rd,
    output dispatcher_pkg::line_step_t  o_step_d
);

    // Unused side stays fully quiet
    always_comb begin
        o_left_rd  = '0;
        o_right_rd = '0;
        if (i_step.valid) begin
            if (i_step.right) begin
                o_right_rd.en   = 1'b1;
                o_right_rd.addr = i_step.src_addr;
            end else begin
                o_left_rd.en    = 1'b1;
                o_left_rd.addr  = i_step.src_addr;
            end
        end
    end

    // ==========================================================
    // One-cycle RAM latency match
    // ==========================================================
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            o_step_d <= '0;
        end else begin
            o_step_d <= i_step;
        end
    end

endmodule

`default_nettype wire

//--- logic/tile_write_port.sv
/*
 * Tile-RAM write port
 * Routes the returning line to the tile write port of the same side,
 * at the delayed destination address, with the column mask
 */
`timescale 1ns/1ps
`default_nettype none

`include "dispatcher_settings.svh"

module tile_write_port (
    input  wire dispatcher_pkg::line_step_t i_step_d,
    input  wire dispatcher_pkg::line_word_t i_left_rd_data,
    input  wire dispatcher_pkg::line_word_t i_right_rd_data,
    output dispatcher_pkg::tile_wr_t    o_left_wr,
    output dispatcher_pkg::tile_wr_t    o_right_wr,
    output logic [`DISP_COLS-1:0]       o_tile_wr_en
);
    import dispatcher_pkg::*;

    line_word_t rd_word;

    // Data comes back on the side that was read
    assign rd_word = i_step_d.right ? i_right_rd_data : i_left_rd_data;

    always_comb begin
        o_left_wr  = '0;
        o_right_wr = '0;
        if (i_step_d.valid) begin
            if (i_step_d.right) begin
                o_right_wr.en   = 1'b1;
                o_right_wr.addr = i_step_d.dst_addr;
                o_right_wr.word = rd_word;
            end else begin
                o_left_wr.en    = 1'b1;
                o_left_wr.addr  = i_step_d.dst_addr;
                o_left_wr.word  = rd_word;
            end
        end
    end

    // Mask is aligned with the write strobe
    assign o_tile_wr_en = i_step_d.valid ? i_step_d.col_mask : '0;

endmodule

`default_nettype wire

//--- test/tb_dispatcher.sv
/*
 * Dispatcher testbench
 * Directed tests around two staging-RAM models and a tile memory model
 * A scoreboard of expected tile writes is filled from the copy rules
 * and is drained by a write monitor
 */
`timescale 1ns/1ps
`default_nettype none

`include "dispatcher_settings.svh"

module tb_dispatcher;
    import dispatcher_pkg::*;

    localparam int depth = 1 << `DISP_ADDR_W;
    // Sum of L+3 over all six transfers, plus idle gaps and reset
    localparam int timeout_cycles = (32 + 3) + (48 + 3) + (24 + 3) + 2 * (16 + 3)
                                  + (0 + 3) + 300;

    // One expected tile write
    typedef struct packed {
        logic                    right;
        logic [`DISP_ADDR_W-1:0] addr;
        logic [`DISP_COLS-1:0]   mask;
        line_word_t              word;
    } exp_wr_t;

    logic                  i_clk;
    logic                  i_reset_n;
    logic                  i_disp_en;
    disp_cmd_t             i_cmd;
    line_word_t            i_left_rd_data = '0;
    line_word_t            i_right_rd_data = '0;
    ram_rd_t               o_left_rd;
    ram_rd_t               o_right_rd;
    tile_wr_t              o_left_wr;
    tile_wr_t              o_right_wr;
    logic [`DISP_COLS-1:0] o_tile_wr_en;
    logic                  o_disp_done;

    line_word_t  left_mem [depth];
    line_word_t  right_mem [depth];
    // Side, column, address
    line_word_t  tile_mem [2][`DISP_COLS][depth];
    exp_wr_t     exp_q[$];
    logic [31:0] salt;
    int          errors = 0;
    int          failures = 0;
    int          done_cnt = 0;
    int          left_rd_cnt = 0;
    int          right_rd_cnt = 0;

    dispatcher_top dut (
        .i_clk           (i_clk),
        .i_reset_n       (i_reset_n),
        .i_disp_en       (i_disp_en),
        .i_cmd           (i_cmd),
        .i_left_rd_data  (i_left_rd_data),
        .i_right_rd_data (i_right_rd_data),
        .o_left_rd       (o_left_rd),
        .o_right_rd      (o_right_rd),
        .o_left_wr       (o_left_wr),
        .o_right_wr      (o_right_wr),
        .o_tile_wr_en    (o_tile_wr_en),
        .o_disp_done     (o_disp_done)
    );

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    // Staging RAMs, one cycle read latency
    always @(posedge i_clk) begin
        if (o_left_rd.en) begin
            i_left_rd_data <= left_mem[o_left_rd.addr];
        end
        if (o_right_rd.en) begin
            i_right_rd_data <= right_mem[o_right_rd.addr];
        end
    end

    // ==========================================================
    // Compare tasks
    // ==========================================================
    task automatic check_word(input string name, input line_word_t got, input line_word_t exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_mask(input string name, input logic [`DISP_COLS-1:0] got,
                              input logic [`DISP_COLS-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input logic [`DISP_ADDR_W-1:0] got,
                              input logic [`DISP_ADDR_W-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            errors++;
            $display("Error at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // Staging contents, unique per side and full address
    function automatic line_word_t stage_pattern(input logic right,
                                                 input logic [`DISP_ADDR_W-1:0] addr);
        line_word_t  w;
        logic [31:0] tag;
        tag   = salt ^ 32'(addr) ^ (32'(right) << 31);
        w.man = {(`DISP_MAN_W / 32){tag}};
        w.exp = `DISP_EXP_W'(addr) ^ {right, 7'd0};
        return w;
    endfunction

    // Write monitor, sampled mid-cycle
    always @(negedge i_clk) begin
        tile_wr_t wr;
        exp_wr_t  e;
        int       side;
        if (i_reset_n) begin
            if (o_left_rd.en) left_rd_cnt++;
            if (o_right_rd.en) right_rd_cnt++;
            if (o_disp_done) done_cnt++;
            if (o_left_wr.en && o_right_wr.en) begin
                failures++;
                $display("Both tile write ports enabled at %0t", $time);
            end
            if (o_left_wr.en || o_right_wr.en) begin
                wr   = o_right_wr.en ? o_right_wr : o_left_wr;
                side = o_right_wr.en ? 1 : 0;
                for (int c = 0; c < `DISP_COLS; c++) begin
                    if (o_tile_wr_en[c]) tile_mem[side][c][wr.addr] = wr.word;
                end
                if (exp_q.size() == 0) begin
                    failures++;
                    $display("Unexpected tile write at %0t to address %h", $time, wr.addr);
                end else begin
                    e = exp_q.pop_front();
                    check_bit("o_right_wr.en", o_right_wr.en, e.right);
                    check_addr("tile write addr", wr.addr, e.addr);
                    check_mask("o_tile_wr_en", o_tile_wr_en, e.mask);
                    check_word("tile write word", wr.word, e.word);
                end
            end else begin
                check_mask("o_tile_wr_en", o_tile_wr_en, '0);
            end
        end
    end

    // ==========================================================
    // Transfer helpers
    // ==========================================================
    // Queue the writes a command must produce, return the line count
    task automatic expect_writes(input disp_cmd_t cmd, output int lines);
        int      bl;
        int      nb;
        int      off;
        int      n;
        int      cols[$];
        exp_wr_t e;
        bl = int'(cmd.vec_size) * `DISP_LINES_PER_VEC;
        nb = (cmd.vec_size == 0) ? 0 : int'(cmd.nv_cnt) / int'(cmd.vec_size);
        for (int c = 0; c < `DISP_COLS; c++) begin
            if (cmd.col_en[c]) cols.push_back(c);
        end
        n = cols.size();
        for (int b = 0; b < nb; b++) begin
            e.mask = '0;
            // One offset per batch in broadcast, one per round in distribute
            if (cmd.broadcast || n == 0) begin
                off = b * bl;
                if (cmd.broadcast) e.mask = cmd.col_en;
            end else begin
                off = (b / n) * bl;
                e.mask[cols[b % n]] = 1'b1;
            end
            for (int j = 0; j < bl; j++) begin
                e.right = cmd.right;
                e.addr  = `DISP_ADDR_W'(int'(cmd.tile_addr) + off + j);
                e.word  = stage_pattern(cmd.right, `DISP_ADDR_W'(b * bl + j));
                exp_q.push_back(e);
            end
        end
        lines = nb * bl;
    endtask

    // Fresh rising edge, optional enable pulse mid-transfer, done timing
    task automatic run_transfer(input disp_cmd_t cmd, input int glitch_at);
        int lines;
        int n;
        int done_before;
        int left_before;
        int right_before;
        expect_writes(cmd, lines);
        done_before  = done_cnt;
        left_before  = left_rd_cnt;
        right_before = right_rd_cnt;
        @(posedge i_clk);
        #1;
        i_cmd     = cmd;
        i_disp_en = 1'b1;
        n         = 0;
        do begin
            @(posedge i_clk);
            #1;
            n++;
            // Command must already be captured
            if (n == 1) i_cmd = ~cmd;
            if (n == glitch_at) i_disp_en = 1'b0;
            if (n == glitch_at + 1) i_disp_en = 1'b1;
        end while (!o_disp_done);
        check_count("done latency", n, lines + 3);
        repeat (3) begin
            @(posedge i_clk);
            #1;
        end
        i_disp_en = 1'b0;
        check_count("done pulses", done_cnt - done_before, 1);
        check_count("pending writes", exp_q.size(), 0);
        check_count("left reads", left_rd_cnt - left_before, cmd.right ? 0 : lines);
        check_count("right reads", right_rd_cnt - right_before, cmd.right ? lines : 0);
    endtask

    task automatic verify_tile_line(input logic right, input int col, input int dst,
                                    input int src);
        check_word($sformatf("tile_mem[%0d][%0d][%0d]", right, col, dst % depth),
                   tile_mem[right][col][`DISP_ADDR_W'(dst)],
                   stage_pattern(right, `DISP_ADDR_W'(src)));
    endtask

    // ==========================================================
    // Directed tests
    // ==========================================================
    task automatic idle_outputs_quiet();
        repeat (10) begin
            @(posedge i_clk);
            #1;
            check_bit("o_left_rd.en", o_left_rd.en, 1'b0);
            check_bit("o_right_rd.en", o_right_rd.en, 1'b0);
            check_bit("o_left_wr.en", o_left_wr.en, 1'b0);
            check_bit("o_right_wr.en", o_right_wr.en, 1'b0);
            check_mask("o_tile_wr_en", o_tile_wr_en, '0);
            check_bit("o_disp_done", o_disp_done, 1'b0);
        end
    endtask

    task automatic distribute_one_column();
        disp_cmd_t cmd;
        cmd = '{tile_addr: 9'h020, nv_cnt: 8'd8, vec_size: 8'd2, col_en: 24'h000004,
                right: 1'b0, broadcast: 1'b0};
        run_transfer(cmd, -1);
        for (int j = 0; j < 32; j++) verify_tile_line(1'b0, 2, 'h20 + j, j);
    endtask

    // Columns 1, 5, 9 in turn, second round one batch further on
    task automatic distribute_three_columns();
        disp_cmd_t cmd;
        int        cols[3];
        cols = '{1, 5, 9};
        cmd  = '{tile_addr: 9'h1f8, nv_cnt: 8'd12, vec_size: 8'd2, col_en: 24'h000222,
                 right: 1'b1, broadcast: 1'b0};
        run_transfer(cmd, -1);
        for (int b = 0; b < 6; b++) begin
            for (int j = 0; j < 8; j++) begin
                verify_tile_line(1'b1, cols[b % 3], 'h1f8 + (b / 3) * 8 + j, b * 8 + j);
            end
        end
    endtask

    task automatic broadcast_four_columns();
        disp_cmd_t cmd;
        cmd = '{tile_addr: 9'h100, nv_cnt: 8'd6, vec_size: 8'd1, col_en: 24'h0000f0,
                right: 1'b0, broadcast: 1'b1};
        run_transfer(cmd, -1);
        for (int c = 4; c < 8; c++) begin
            for (int j = 0; j < 24; j++) verify_tile_line(1'b0, c, 'h100 + j, j);
        end
    endtask

    // Enable held high, dropped and raised mid-transfer, then a new edge
    task automatic enable_held_and_pulsed();
        disp_cmd_t cmd;
        cmd = '{tile_addr: 9'h040, nv_cnt: 8'd4, vec_size: 8'd1, col_en: 24'h800001,
                right: 1'b0, broadcast: 1'b0};
        run_transfer(cmd, 6);
        cmd.right = 1'b1;
        run_transfer(cmd, -1);
    endtask

    // Fewer vectors than one batch
    task automatic short_vector_count();
        disp_cmd_t cmd;
        cmd = '{tile_addr: 9'h080, nv_cnt: 8'd1, vec_size: 8'd3, col_en: 24'h00000f,
                right: 1'b0, broadcast: 1'b1};
        run_transfer(cmd, -1);
    endtask

    initial begin
        void'($urandom(67));
        salt      = $urandom();
        i_reset_n = 1'b0;
        i_disp_en = 1'b0;
        i_cmd     = '0;
        for (int a = 0; a < depth; a++) begin
            left_mem[a]  = stage_pattern(1'b0, `DISP_ADDR_W'(a));
            right_mem[a] = stage_pattern(1'b1, `DISP_ADDR_W'(a));
        end
        repeat (3) @(posedge i_clk);
        #1;
        i_reset_n = 1'b1;
        idle_outputs_quiet();
        distribute_one_column();
        distribute_three_columns();
        broadcast_four_columns();
        enable_held_and_pulsed();
        short_vector_count();
        repeat (5) @(posedge i_clk);
        $display("Summary: %0d errors, %0d failures", errors, failures);
        if (errors == 0 && failures == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Run limit
    initial begin
        int cyc;
        cyc = 0;
        while (cyc < timeout_cycles) begin
            @(posedge i_clk);
            cyc++;
        end
        $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+include
logic/dispatcher_pkg.sv
logic/dispatch_ctrl.sv
logic/batch_walker.sv
logic/stage_read_port.sv
logic/tile_write_port.sv
logic/dispatcher_top.sv
test/tb_dispatcher.sv
